// File: src/nts_disp_pkg.sv
//----------------------------
// Shared widths, types, FSM states and register map for the
// receive dispatcher. Modules import it inside their body.
//----------------------------
`default_nettype none

package nts_disp_pkg;

  localparam int ADDR_WIDTH   = 8;  // Words per bank, log2
  localparam int NUM_COUNTERS = 6;

  typedef logic [63:0]           word_t;
  typedef logic [7:0]            valid_t;  // Bit 0 is the lowest input byte
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [63:0]           counter_t;
  typedef logic [11:0]           api_addr_t;
  typedef logic [31:0]           api_data_t;

  // Finished frame, writer to reader
  typedef struct packed {
    addr_t  last_addr;
    valid_t last_valid;
  } frame_desc_t;

  typedef struct packed {
    word_t  data;   // Byte reversed, invalid bytes zeroed
    valid_t valid;  // Raw mask
    logic   sof;
  } rx_word_t;

  typedef struct packed {
    logic       sof;
    logic       good;
    logic       bad;
    logic       dispatched;
    logic       error;
    logic       byte_valid;
    logic [3:0] bytes;
  } stat_events_t;

  typedef enum logic [1:0] {RX_EMPTY, RX_HAS_DATA, RX_RECEIVED, RX_ERROR} rx_state_e;

  typedef enum logic [2:0] {
    TX_EMPTY, TX_AVAILABLE, TX_PRIME, TX_OUT, TX_LAST, TX_DONE
  } tx_state_e;

  //----------------------------
  // Register map
  localparam api_addr_t ADDR_NAME0                  = 12'h000;
  localparam api_addr_t ADDR_NAME1                  = 12'h001;
  localparam api_addr_t ADDR_VERSION                = 12'h002;
  localparam api_addr_t ADDR_STATES_INSPECT         = 12'h005;
  localparam api_addr_t ADDR_BYTES_RX_MSB           = 12'h00a;
  localparam api_addr_t ADDR_BYTES_RX_LSB           = 12'h00b;
  localparam api_addr_t ADDR_COUNTER_FRAMES_MSB     = 12'h020;
  localparam api_addr_t ADDR_COUNTER_FRAMES_LSB     = 12'h021;
  localparam api_addr_t ADDR_COUNTER_GOOD_MSB       = 12'h022;
  localparam api_addr_t ADDR_COUNTER_GOOD_LSB       = 12'h023;
  localparam api_addr_t ADDR_COUNTER_BAD_MSB        = 12'h024;
  localparam api_addr_t ADDR_COUNTER_BAD_LSB        = 12'h025;
  localparam api_addr_t ADDR_COUNTER_DISPATCHED_MSB = 12'h026;
  localparam api_addr_t ADDR_COUNTER_DISPATCHED_LSB = 12'h027;
  localparam api_addr_t ADDR_COUNTER_ERROR_MSB      = 12'h028;
  localparam api_addr_t ADDR_COUNTER_ERROR_LSB      = 12'h029;
  localparam api_addr_t ADDR_LAST                   = 12'hfff;

  // Counter slots, in the order of the address tables below
  localparam int CNT_FRAMES     = 0;
  localparam int CNT_GOOD       = 1;
  localparam int CNT_BAD        = 2;
  localparam int CNT_DISPATCHED = 3;
  localparam int CNT_BYTES      = 4;
  localparam int CNT_ERROR      = 5;

  localparam api_addr_t CNT_MSB_ADDR [NUM_COUNTERS] = '{
    ADDR_COUNTER_FRAMES_MSB, ADDR_COUNTER_GOOD_MSB, ADDR_COUNTER_BAD_MSB,
    ADDR_COUNTER_DISPATCHED_MSB, ADDR_BYTES_RX_MSB, ADDR_COUNTER_ERROR_MSB
  };
  localparam api_addr_t CNT_LSB_ADDR [NUM_COUNTERS] = '{
    ADDR_COUNTER_FRAMES_LSB, ADDR_COUNTER_GOOD_LSB, ADDR_COUNTER_BAD_LSB,
    ADDR_COUNTER_DISPATCHED_LSB, ADDR_BYTES_RX_LSB, ADDR_COUNTER_ERROR_LSB
  };

  localparam logic [63:0] CORE_NAME    = 64'h4e_54_53_2d_44_49_53_50;  // NTS-DISP
  localparam api_data_t   CORE_VERSION = 32'h30_2e_30_32;              // 0.02
  localparam api_data_t   LAST_MAGIC   = 32'hf005_ba11;

endpackage

`default_nettype wire

// File: src/bram.sv
//----------------------------
// Single-port RAM, one buffer bank
// Read data is registered, one cycle after the address
//----------------------------
`timescale 1ns/10ps
`default_nettype none

module bram (
  input  wire                      i_clk,
  input  wire nts_disp_pkg::addr_t i_addr,
  input  wire                      i_write,
  input  wire nts_disp_pkg::word_t i_data,
  output nts_disp_pkg::word_t      o_data
);
  import nts_disp_pkg::*;

  word_t mem [2**ADDR_WIDTH];

  always_ff @(posedge i_clk)
  begin
    if (i_write)
      mem[i_addr] <= i_data;
    o_data <= mem[i_addr];  // Old data on a write cycle
  end

endmodule

`default_nettype wire

// File: src/frame_buffer.sv
//----------------------------
// Ping-pong frame store. The current bank takes writes,
// the other one is read by the dispatch side.
//----------------------------
`timescale 1ns/10ps
`default_nettype none

module frame_buffer (
  input  wire                      i_clk,
  input  wire                      i_areset,
  input  wire                      i_bank,
  input  wire                      i_wr_en,
  input  wire nts_disp_pkg::addr_t i_wr_addr,
  input  wire nts_disp_pkg::word_t i_wr_data,
  input  wire nts_disp_pkg::addr_t i_rd_addr,
  output nts_disp_pkg::word_t      o_rd_data
);
  import nts_disp_pkg::*;

  logic  wr_en_q;
  logic  wr_bank_q;  // Bank the pending write belongs to
  addr_t wr_addr_q;
  word_t wr_data_q;
  word_t bank_data [2];

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      wr_en_q   <= 1'b0;
      wr_bank_q <= 1'b0;
    end
    else
    begin
      wr_en_q   <= i_wr_en;
      wr_bank_q <= i_bank;
    end
  end

  always_ff @(posedge i_clk)
  begin
    wr_addr_q <= i_wr_addr;
    wr_data_q <= i_wr_data;
  end

  for (genvar b = 0; b < 2; b++)
  begin : g_bank
    logic write;

    assign write = wr_en_q && (wr_bank_q == 1'(b));

    bram u_bram (
      .i_clk   (i_clk),
      .i_addr  (write ? wr_addr_q : i_rd_addr),
      .i_write (write),
      .i_data  (wr_data_q),
      .o_data  (bank_data[b])
    );
  end

  assign o_rd_data = bank_data[!i_bank];  // Dispatch side

endmodule

`default_nettype wire

// File: src/rx_frontend.sv
//----------------------------
// MAC receive input stage. Reverses byte order, counts
// valid bytes and flags the start of a frame.
//----------------------------
`timescale 1ns/10ps
`default_nettype none

module rx_frontend (
  input  wire                       i_clk,
  input  wire                       i_areset,
  input  wire nts_disp_pkg::valid_t i_rx_data_valid,
  input  wire nts_disp_pkg::word_t  i_rx_data,
  output nts_disp_pkg::rx_word_t    o_rx,
  output logic [3:0]                o_bytes
);
  import nts_disp_pkg::*;

  valid_t prev_valid_q;
  word_t  corrected;

  // All ones at reset, so a frame already running is not taken as new
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
      prev_valid_q <= '1;
    else
      prev_valid_q <= i_rx_data_valid;
  end

  // Lowest input byte ends up in the top byte
  always_comb
  begin
    for (int b = 0; b < 8; b++)
      corrected[8*(7-b) +: 8] = i_rx_data_valid[b] ? i_rx_data[8*b +: 8] : 8'h00;
  end

  // Only masks packed from bit 0 carry a count
  always_comb
  begin
    o_bytes = 4'd0;
    for (int n = 1; n <= 8; n++)
    begin
      if (i_rx_data_valid == valid_t'((9'h1 << n) - 1'b1))
        o_bytes = 4'(n);
    end
  end

  assign o_rx = '{
    data:  corrected,
    valid: i_rx_data_valid,
    sof:   (prev_valid_q == '0) && (i_rx_data_valid == '1)  // Idle then full word
  };

endmodule

`default_nettype wire

// File: src/frame_writer.sv
//----------------------------
// Receive FSM. Fills the current bank and hands a good
// frame to the reader by swapping banks.
//----------------------------
`timescale 1ns/10ps
`default_nettype none

module frame_writer (
  input  wire                            i_clk,
  input  wire                            i_areset,
  input  wire nts_disp_pkg::rx_word_t    i_rx,
  input  wire                            i_rx_good_frame,
  input  wire                            i_rx_bad_frame,
  input  wire                            i_reader_idle,
  output logic                           o_bank,
  output logic                           o_wr_en,
  output nts_disp_pkg::addr_t            o_wr_addr,
  output nts_disp_pkg::word_t            o_wr_data,
  output logic                           o_handover,
  output nts_disp_pkg::frame_desc_t      o_frame,
  output logic                           o_error,
  output nts_disp_pkg::rx_state_e        o_state
);
  import nts_disp_pkg::*;

  rx_state_e state_q;
  rx_state_e state_d;
  addr_t     last_q;  // Address of the last word written
  addr_t     last_d;
  valid_t    mask_q;  // Mask of the final word
  valid_t    mask_d;
  logic      bank_q;

  always_comb
  begin
    state_d    = state_q;
    last_d     = last_q;
    mask_d     = mask_q;
    o_wr_en    = 1'b0;
    o_wr_addr  = '0;
    o_handover = 1'b0;

    if (i_rx_bad_frame)
    begin
      state_d = RX_EMPTY;
      last_d  = '0;
      mask_d  = '0;
    end
    else
    begin
      case (state_q)
        RX_EMPTY:
          if (i_rx.sof)
          begin
            state_d = RX_HAS_DATA;
            last_d  = '0;
            mask_d  = '0;
            o_wr_en = 1'b1;  // Word 0
          end
        RX_HAS_DATA:
          if (last_q == '1)
            state_d = RX_ERROR;  // Bank full, drop frame
          else
          begin
            if (i_rx.valid != '0)
            begin
              o_wr_en   = 1'b1;
              o_wr_addr = last_q + 1'b1;
              last_d    = last_q + 1'b1;
            end
            if (i_rx_good_frame)
            begin
              mask_d  = i_rx.valid;
              state_d = RX_RECEIVED;
            end
          end
        RX_RECEIVED:
          if (i_reader_idle)
          begin
            o_handover = 1'b1;
            state_d    = RX_EMPTY;
          end
        default:
          state_d = RX_EMPTY;
      endcase
    end
  end

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      state_q <= RX_EMPTY;
      last_q  <= '0;
      mask_q  <= '0;
      bank_q  <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      last_q  <= last_d;
      mask_q  <= mask_d;
      bank_q  <= bank_q ^ o_handover;  // Swap on handover
    end
  end

  assign o_wr_data = i_rx.data;
  assign o_bank    = bank_q;
  assign o_frame   = '{last_addr: last_q, last_valid: mask_q};
  assign o_error   = (state_q == RX_ERROR);
  assign o_state   = state_q;

endmodule

`default_nettype wire

// File: src/frame_reader.sv
//----------------------------
// Dispatch FSM. Announces a handed-over frame, streams it
// as a burst on request and waits for the discard.
//----------------------------
`timescale 1ns/10ps
`default_nettype none

module frame_reader (
  input  wire                            i_clk,
  input  wire                            i_areset,
  input  wire                            i_handover,
  input  wire nts_disp_pkg::frame_desc_t i_frame,
  input  wire nts_disp_pkg::word_t       i_rd_data,
  input  wire                            i_fifo_rd_start,
  input  wire                            i_packet_read_discard,
  output logic                           o_idle,
  output nts_disp_pkg::addr_t            o_rd_addr,
  output logic                           o_packet_available,
  output nts_disp_pkg::addr_t            o_dispatch_counter,
  output nts_disp_pkg::valid_t           o_dispatch_data_valid,
  output logic                           o_fifo_empty,
  output logic                           o_fifo_rd_valid,
  output nts_disp_pkg::word_t            o_fifo_rd_data,
  output nts_disp_pkg::tx_state_e        o_state
);
  import nts_disp_pkg::*;

  tx_state_e   state_q;
  tx_state_e   state_d;
  frame_desc_t desc_q;
  addr_t       rd_addr_q;
  addr_t       rd_addr_d;
  logic        rd_valid_q;
  logic        rd_valid_d;
  logic        fifo_empty_q;
  word_t       rd_data_q;

  // RAM data lags the address by one cycle, so in TX_OUT
  // the word at rd_addr_q - 1 is on i_rd_data
  always_comb
  begin
    state_d    = state_q;
    rd_addr_d  = '0;
    rd_valid_d = 1'b0;

    if (i_packet_read_discard && state_q != TX_EMPTY)
      state_d = TX_EMPTY;
    else
    begin
      case (state_q)
        TX_EMPTY:
          if (i_handover)
            state_d = TX_AVAILABLE;
        TX_AVAILABLE:
          if (i_fifo_rd_start)
            state_d = TX_PRIME;  // Word 0 being fetched
        TX_PRIME:
          if (desc_q.last_addr == '0)
            state_d = TX_LAST;
          else
          begin
            state_d   = TX_OUT;
            rd_addr_d = addr_t'(1);
          end
        TX_OUT:
          begin
            rd_valid_d = 1'b1;
            rd_addr_d  = rd_addr_q + 1'b1;
            if (rd_addr_q == desc_q.last_addr)
              state_d = TX_LAST;
          end
        TX_LAST:
          begin
            rd_valid_d = 1'b1;
            state_d    = TX_DONE;
          end
        default: ;  // TX_DONE holds until discard
      endcase
    end
  end

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      state_q      <= TX_EMPTY;
      desc_q       <= '0;
      rd_addr_q    <= '0;
      rd_valid_q   <= 1'b0;
      fifo_empty_q <= 1'b0;
    end
    else
    begin
      state_q    <= state_d;
      rd_addr_q  <= rd_addr_d;
      rd_valid_q <= rd_valid_d;
      if (i_handover && state_q == TX_EMPTY)
        desc_q <= i_frame;
      // Low one cycle behind the read states, covering the burst
      fifo_empty_q <= !(state_q inside {TX_PRIME, TX_OUT, TX_LAST});
    end
  end

  always_ff @(posedge i_clk)
    rd_data_q <= i_rd_data;

  assign o_idle                = (state_q == TX_EMPTY);
  assign o_rd_addr             = rd_addr_q;
  assign o_packet_available    = (state_q == TX_AVAILABLE);
  assign o_dispatch_counter    = desc_q.last_addr;
  assign o_dispatch_data_valid = desc_q.last_valid;
  assign o_fifo_empty          = fifo_empty_q;
  assign o_fifo_rd_valid       = rd_valid_q;
  assign o_fifo_rd_data        = rd_data_q;
  assign o_state               = state_q;

endmodule

`default_nettype wire

// File: src/stats_regs.sv
//----------------------------
// Statistics counters and the read-only register decoder.
// Reading a counter MSB latches its LSB for the next read.
//----------------------------
`timescale 1ns/10ps
`default_nettype none

module stats_regs (
  input  wire                             i_clk,
  input  wire                             i_areset,
  input  wire nts_disp_pkg::stat_events_t i_events,
  input  wire                             i_bank,
  input  wire nts_disp_pkg::rx_state_e    i_rx_state,
  input  wire nts_disp_pkg::tx_state_e    i_tx_state,
  input  wire                             i_api_cs,
  input  wire                             i_api_we,
  input  wire nts_disp_pkg::api_addr_t    i_api_address,
  output nts_disp_pkg::api_data_t         o_api_read_data
);
  import nts_disp_pkg::*;

  counter_t                count_q [NUM_COUNTERS];
  api_data_t               lsb_q   [NUM_COUNTERS];
  counter_t                inc     [NUM_COUNTERS];
  logic [NUM_COUNTERS-1:0] snap;
  api_data_t               read_data;

  always_comb
  begin
    inc[CNT_FRAMES]     = counter_t'(i_events.sof);
    inc[CNT_GOOD]       = counter_t'(i_events.good);
    inc[CNT_BAD]        = counter_t'(i_events.bad);
    inc[CNT_DISPATCHED] = counter_t'(i_events.dispatched);
    inc[CNT_BYTES]      = i_events.byte_valid ? counter_t'(i_events.bytes) : '0;
    inc[CNT_ERROR]      = counter_t'(i_events.error);  // Cycles spent in error
  end

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      for (int i = 0; i < NUM_COUNTERS; i++)
      begin
        count_q[i] <= '0;
        lsb_q[i]   <= '0;
      end
    end
    else
    begin
      for (int i = 0; i < NUM_COUNTERS; i++)
      begin
        count_q[i] <= count_q[i] + inc[i];
        if (snap[i])
          lsb_q[i] <= count_q[i][31:0];
      end
    end
  end

  //----------------------------
  // Read decoder
  always_comb
  begin
    read_data = '0;
    snap      = '0;
    if (i_api_cs && !i_api_we)
    begin
      case (i_api_address)
        ADDR_NAME0:          read_data = CORE_NAME[63:32];
        ADDR_NAME1:          read_data = CORE_NAME[31:0];
        ADDR_VERSION:        read_data = CORE_VERSION;
        ADDR_STATES_INSPECT:
          read_data = {15'h0, i_bank, 4'h0, 4'(i_rx_state), 4'h0, 4'(i_tx_state)};
        ADDR_LAST:           read_data = LAST_MAGIC;
        default:             read_data = '0;
      endcase
      for (int i = 0; i < NUM_COUNTERS; i++)
      begin
        if (i_api_address == CNT_MSB_ADDR[i])
        begin
          read_data = count_q[i][63:32];
          snap[i]   = 1'b1;
        end
        if (i_api_address == CNT_LSB_ADDR[i])
          read_data = lsb_q[i];
      end
    end
  end

  assign o_api_read_data = read_data;

endmodule

`default_nettype wire

// File: src/nts_dispatcher.sv
//----------------------------
// Receive dispatcher top level. MAC words in, frames out
// as read bursts, statistics on the register port.
//----------------------------
`timescale 1ns/10ps
`default_nettype none

module nts_dispatcher (
  input  wire                          i_clk,
  input  wire                          i_areset,
  input  wire nts_disp_pkg::valid_t    i_rx_data_valid,
  input  wire nts_disp_pkg::word_t     i_rx_data,
  input  wire                          i_rx_bad_frame,
  input  wire                          i_rx_good_frame,
  output logic                         o_packet_available,
  input  wire                          i_packet_read_discard,
  output nts_disp_pkg::addr_t          o_dispatch_counter,
  output nts_disp_pkg::valid_t         o_dispatch_data_valid,
  output logic                         o_fifo_empty,
  input  wire                          i_fifo_rd_start,
  output logic                         o_fifo_rd_valid,
  output nts_disp_pkg::word_t          o_fifo_rd_data,
  input  wire                          i_api_cs,
  input  wire                          i_api_we,
  input  wire nts_disp_pkg::api_addr_t i_api_address,
  output nts_disp_pkg::api_data_t      o_api_read_data
);
  import nts_disp_pkg::*;

  rx_word_t     rx;
  logic [3:0]   rx_bytes;
  logic         bank;  // Bank owned by the receive side
  logic         wr_en;
  addr_t        wr_addr;
  word_t        wr_data;
  logic         handover;
  frame_desc_t  frame;
  logic         writer_error;
  rx_state_e    rx_state;
  logic         reader_idle;
  addr_t        rd_addr;
  word_t        rd_data;
  tx_state_e    tx_state;
  stat_events_t events;

  rx_frontend u_frontend (
    .i_clk           (i_clk),
    .i_areset        (i_areset),
    .i_rx_data_valid (i_rx_data_valid),
    .i_rx_data       (i_rx_data),
    .o_rx            (rx),
    .o_bytes         (rx_bytes)
  );

  frame_writer u_writer (
    .i_clk           (i_clk),
    .i_areset        (i_areset),
    .i_rx            (rx),
    .i_rx_good_frame (i_rx_good_frame),
    .i_rx_bad_frame  (i_rx_bad_frame),
    .i_reader_idle   (reader_idle),
    .o_bank          (bank),
    .o_wr_en         (wr_en),
    .o_wr_addr       (wr_addr),
    .o_wr_data       (wr_data),
    .o_handover      (handover),
    .o_frame         (frame),
    .o_error         (writer_error),
    .o_state         (rx_state)
  );

  frame_buffer u_buffer (
    .i_clk     (i_clk),
    .i_areset  (i_areset),
    .i_bank    (bank),
    .i_wr_en   (wr_en),
    .i_wr_addr (wr_addr),
    .i_wr_data (wr_data),
    .i_rd_addr (rd_addr),
    .o_rd_data (rd_data)
  );

  frame_reader u_reader (
    .i_clk                 (i_clk),
    .i_areset              (i_areset),
    .i_handover            (handover),
    .i_frame               (frame),
    .i_rd_data             (rd_data),
    .i_fifo_rd_start       (i_fifo_rd_start),
    .i_packet_read_discard (i_packet_read_discard),
    .o_idle                (reader_idle),
    .o_rd_addr             (rd_addr),
    .o_packet_available    (o_packet_available),
    .o_dispatch_counter    (o_dispatch_counter),
    .o_dispatch_data_valid (o_dispatch_data_valid),
    .o_fifo_empty          (o_fifo_empty),
    .o_fifo_rd_valid       (o_fifo_rd_valid),
    .o_fifo_rd_data        (o_fifo_rd_data),
    .o_state               (tx_state)
  );

  // Statistics sample the MAC strobes directly
  assign events = '{
    sof:        rx.sof,
    good:       i_rx_good_frame,
    bad:        i_rx_bad_frame,
    dispatched: i_fifo_rd_start,
    error:      writer_error,
    byte_valid: (rx_bytes != 4'd0),
    bytes:      rx_bytes
  };

  stats_regs u_stats (
    .i_clk           (i_clk),
    .i_areset        (i_areset),
    .i_events        (events),
    .i_bank          (bank),
    .i_rx_state      (rx_state),
    .i_tx_state      (tx_state),
    .i_api_cs        (i_api_cs),
    .i_api_we        (i_api_we),
    .i_api_address   (i_api_address),
    .o_api_read_data (o_api_read_data)
  );

endmodule

`default_nettype wire

// File: bench/nts_dispatcher_sva.sv
//----------------------------
// Concurrent checks on the dispatch outputs and the bank
// swap, bound into the dispatcher top level
//----------------------------
`timescale 1ns/10ps
`default_nettype none

module nts_dispatcher_sva (
  input wire                          i_clk,
  input wire                          i_areset,
  input wire                          i_packet_available,
  input wire                          i_fifo_rd_valid,
  input wire                          i_fifo_empty,
  input wire                          i_bank,
  input wire                          i_handover,
  input wire nts_disp_pkg::tx_state_e i_tx_state
);
  import nts_disp_pkg::*;

  int fail_count = 0;

  // No burst while the frame is only announced
  a_valid_not_announced: assert property (
    @(posedge i_clk) disable iff (i_areset)
    $rose(i_fifo_rd_valid) |-> !i_packet_available
  ) else
  begin
    fail_count++;
    $error("o_fifo_rd_valid rose while o_packet_available was high");
  end

  // Swap only on a handover, and only while the reader holds no frame
  a_bank_on_handover: assert property (
    @(posedge i_clk) disable iff (i_areset)
    $changed(i_bank) |-> ($past(i_handover) && $past(i_tx_state) == TX_EMPTY)
  ) else
  begin
    fail_count++;
    $error("Bank changed without a handover to an idle reader");
  end

  // Settled idle reader
  a_idle_flags: assert property (
    @(posedge i_clk) disable iff (i_areset)
    (!$past(i_areset) && i_tx_state == TX_EMPTY && $past(i_tx_state) == TX_EMPTY)
      |-> (i_packet_available || i_fifo_empty)
  ) else
  begin
    fail_count++;
    $error("o_packet_available and o_fifo_empty both low in TX_EMPTY");
  end

endmodule

bind nts_dispatcher nts_dispatcher_sva u_sva (
  .i_clk              (i_clk),
  .i_areset           (i_areset),
  .i_packet_available (o_packet_available),
  .i_fifo_rd_valid    (o_fifo_rd_valid),
  .i_fifo_empty       (o_fifo_empty),
  .i_bank             (bank),
  .i_handover         (handover),
  .i_tx_state         (tx_state)
);

`default_nettype wire

// File: bench/tb_nts_dispatcher.sv
//----------------------------
// Testbench for the receive dispatcher. Random frames go
// in, bursts come out and are compared with a queue model.
//----------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_nts_dispatcher;
  import nts_disp_pkg::*;

  localparam int NUM_FRAMES = 20;
  localparam int MAX_WORDS  = 30;
  // 25 frames of under 100 cycles plus a 300 word frame and reads
  localparam int CYCLE_LIMIT = 20000;
  localparam logic [63:0] EXP_NAME    = "NTS-DISP";
  localparam logic [31:0] EXP_VERSION = "0.02";

  logic      clk;
  logic      areset;
  valid_t    rx_valid;
  word_t     rx_data;
  logic      rx_good;
  logic      rx_bad;
  logic      discard;
  logic      rd_start;
  logic      api_cs;
  logic      api_we;
  api_addr_t api_addr;
  logic      packet_available;
  addr_t     dispatch_counter;
  valid_t    dispatch_valid;
  logic      fifo_empty;
  logic      rd_valid;
  word_t     rd_data;
  api_data_t api_rdata;

  int     seed = 73;
  int     cycles = 0;
  int     checks = 0;
  int     errors = 0;
  int     tests = 0;
  word_t  exp_words [$];  // Expected words of all queued frames in order
  int     exp_len [$];
  valid_t exp_mask [$];
  logic [63:0] n_frames = 0;
  logic [63:0] n_good = 0;
  logic [63:0] n_bad = 0;
  logic [63:0] n_dispatched = 0;
  logic [63:0] n_bytes = 0;

  nts_dispatcher i_nts_dispatcher (
    .i_clk                 (clk),
    .i_areset              (areset),
    .i_rx_data_valid       (rx_valid),
    .i_rx_data             (rx_data),
    .i_rx_bad_frame        (rx_bad),
    .i_rx_good_frame       (rx_good),
    .o_packet_available    (packet_available),
    .i_packet_read_discard (discard),
    .o_dispatch_counter    (dispatch_counter),
    .o_dispatch_data_valid (dispatch_valid),
    .o_fifo_empty          (fifo_empty),
    .i_fifo_rd_start       (rd_start),
    .o_fifo_rd_valid       (rd_valid),
    .o_fifo_rd_data        (rd_data),
    .i_api_cs              (api_cs),
    .i_api_we              (api_we),
    .i_api_address         (api_addr),
    .o_api_read_data       (api_rdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("Timeout after %0d cycles, run did not complete", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  //----------------------------
  // Statistics model of the MAC side strobes seen each cycle
  always @(posedge clk)
  begin
    if (!areset)
    begin
      n_good       = n_good + rx_good;
      n_bad        = n_bad + rx_bad;
      n_dispatched = n_dispatched + rd_start;
      n_bytes      = n_bytes + byte_count(rx_valid);
    end
  end

  // First input byte lands in the top byte
  function automatic word_t expected_word(input word_t raw, input valid_t mask);
    word_t result;
    result = '0;
    for (int b = 0; b < 8; b++)
      if (mask[b])
        result[63 - 8*b -: 8] = raw[8*b +: 8];
    return result;
  endfunction

  function automatic int byte_count(input valid_t mask);
    int ones;
    ones = $countones(mask);
    if (mask == valid_t'((1 << ones) - 1))
      return ones;
    return 0;  // Holes in the mask
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    checks++;
    if (got !== expected)
    begin
      $display("Mismatch %s: got %h expected %h", name, got, expected);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int start_errors);
    tests++;
    if (errors == start_errors)
      $display("%s: passed", name);
    else
      $display("%s: failed with %0d errors", name, errors - start_errors);
  endtask

  //----------------------------
  // Frame stimulus followed by an idle gap so the next sof is seen
  task automatic send_frame(input int words, input logic good, input logic keep);
    word_t  data;
    valid_t mask;
    int     nbytes;
    int     gap;
    n_frames = n_frames + 1;  // Every frame starts after idle
    for (int w = 0; w < words; w++)
    begin
      data = {$random(seed), $random(seed)};
      mask = 8'hff;
      if (w == words - 1)
      begin
        nbytes = 1 + ($unsigned($random(seed)) % 8);
        mask   = valid_t'((1 << nbytes) - 1);
      end
      if (keep)
        exp_words.push_back(expected_word(data, mask));
      @(posedge clk);
      rx_valid <= mask;
      rx_data  <= data;
      rx_good  <= good && (w == words - 1);
      rx_bad   <= !good && (w == words - 1);
    end
    if (keep)
    begin
      exp_len.push_back(words);
      exp_mask.push_back(mask);
    end
    gap = 1 + ($unsigned($random(seed)) % 8);
    repeat (gap)
    begin
      @(posedge clk);
      rx_valid <= '0;
      rx_data  <= '0;
      rx_good  <= 1'b0;
      rx_bad   <= 1'b0;
    end
  endtask

  // Wait for the announcement, read the burst and release the frame
  task automatic receive_frame();
    int    len;
    int    n;
    int    waited;
    word_t exp;
    len = exp_len.pop_front();
    waited = 0;
    while (!packet_available && waited < 200)
    begin
      @(posedge clk);
      waited++;
    end
    if (!packet_available)
    begin
      $display("Frame was not announced within 200 cycles");
      errors++;
    end
    check_value("o_dispatch_counter", dispatch_counter, len - 1);
    check_value("o_dispatch_data_valid", dispatch_valid, exp_mask.pop_front());
    check_value("o_fifo_empty", fifo_empty, 1);
    @(posedge clk);
    rd_start <= 1'b1;
    @(posedge clk);
    rd_start <= 1'b0;
    waited = 0;
    while (!rd_valid && waited < 10)
    begin
      @(posedge clk);
      waited++;
    end
    n = 0;
    while (rd_valid)
    begin
      check_value("o_fifo_empty", fifo_empty, 0);
      if (n < len)
      begin
        exp = exp_words.pop_front();
        check_value("o_fifo_rd_data", rd_data, exp);
      end
      n++;
      @(posedge clk);
    end
    for (int i = n; i < len; i++)
      exp = exp_words.pop_front();
    check_value("o_fifo_rd_valid word count", n, len);
    @(posedge clk);
    discard <= 1'b1;
    @(posedge clk);
    discard <= 1'b0;
  endtask

  task automatic expect_silent(input string what);
    logic seen;
    seen = 1'b0;
    repeat (20)
    begin
      @(posedge clk);
      seen = seen | packet_available;
    end
    checks++;
    if (seen)
    begin
      $display("A %s was announced although it must be dropped", what);
      errors++;
    end
  endtask

  task automatic read_reg(input api_addr_t addr, output api_data_t data);
    @(posedge clk);
    api_cs   <= 1'b1;
    api_we   <= 1'b0;
    api_addr <= addr;
    @(posedge clk);
    data = api_rdata;
    api_cs <= 1'b0;
  endtask

  task automatic read_counter(input api_addr_t msb, input api_addr_t lsb,
                              output logic [63:0] value);
    api_data_t hi;
    api_data_t lo;
    read_reg(msb, hi);
    read_reg(lsb, lo);  // Snapshot taken with the MSB read
    value = {hi, lo};
  endtask

  //----------------------------
  // Test sequence
  initial
  begin
    int          start;
    api_data_t   data;
    logic [63:0] count;

    areset   = 1'b1;
    rx_valid = '0;
    rx_data  = '0;
    rx_good  = 1'b0;
    rx_bad   = 1'b0;
    discard  = 1'b0;
    rd_start = 1'b0;
    api_cs   = 1'b0;
    api_we   = 1'b0;
    api_addr = '0;
    repeat (5) @(posedge clk);
    areset <= 1'b0;
    repeat (3) @(posedge clk);

    start = errors;
    check_value("o_packet_available", packet_available, 0);
    check_value("o_fifo_rd_valid", rd_valid, 0);
    check_value("o_api_read_data", api_rdata, 0);
    read_reg(ADDR_NAME0, data);
    check_value("o_api_read_data", data, EXP_NAME[63:32]);
    read_reg(ADDR_NAME1, data);
    check_value("o_api_read_data", data, EXP_NAME[31:0]);
    read_reg(ADDR_VERSION, data);
    check_value("o_api_read_data", data, EXP_VERSION);
    read_reg(ADDR_LAST, data);
    check_value("o_api_read_data", data, LAST_MAGIC);
    report_test("identity", start);

    start = errors;
    for (int f = 0; f < NUM_FRAMES; f++)
    begin
      send_frame(2 + ($unsigned($random(seed)) % (MAX_WORDS - 1)), 1'b1, 1'b1);
      receive_frame();
    end
    report_test("frame round trip", start);

    // Second frame waits in the writer while the first is announced
    start = errors;
    send_frame(2 + ($unsigned($random(seed)) % (MAX_WORDS - 1)), 1'b1, 1'b1);
    send_frame(2 + ($unsigned($random(seed)) % (MAX_WORDS - 1)), 1'b1, 1'b1);
    receive_frame();
    receive_frame();
    report_test("double buffering", start);

    start = errors;
    send_frame(2 + ($unsigned($random(seed)) % (MAX_WORDS - 1)), 1'b0, 1'b0);
    expect_silent("bad frame");
    send_frame(2 + ($unsigned($random(seed)) % (MAX_WORDS - 1)), 1'b1, 1'b1);
    receive_frame();
    report_test("bad frame", start);

    start = errors;
    send_frame(300, 1'b1, 1'b0);
    expect_silent("overflowed frame");
    read_counter(ADDR_COUNTER_ERROR_MSB, ADDR_COUNTER_ERROR_LSB, count);
    checks++;
    if (count == 0)
    begin
      $display("Error counter stayed at zero after an overflow");
      errors++;
    end
    send_frame(2 + ($unsigned($random(seed)) % (MAX_WORDS - 1)), 1'b1, 1'b1);
    receive_frame();
    report_test("overflow", start);

    start = errors;
    read_counter(ADDR_COUNTER_FRAMES_MSB, ADDR_COUNTER_FRAMES_LSB, count);
    check_value("frames counter", count, n_frames);
    read_counter(ADDR_COUNTER_GOOD_MSB, ADDR_COUNTER_GOOD_LSB, count);
    check_value("good counter", count, n_good);
    read_counter(ADDR_COUNTER_BAD_MSB, ADDR_COUNTER_BAD_LSB, count);
    check_value("bad counter", count, n_bad);
    read_counter(ADDR_COUNTER_DISPATCHED_MSB, ADDR_COUNTER_DISPATCHED_LSB, count);
    check_value("dispatched counter", count, n_dispatched);
    read_counter(ADDR_BYTES_RX_MSB, ADDR_BYTES_RX_LSB, count);
    check_value("bytes counter", count, n_bytes);
    report_test("statistics", start);

    checks++;
    if (i_nts_dispatcher.u_sva.fail_count != 0)
    begin
      $display("Bound assertions failed %0d times", i_nts_dispatcher.u_sva.fail_count);
      errors++;
    end

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
src/nts_disp_pkg.sv
src/bram.sv
src/frame_buffer.sv
src/rx_frontend.sv
src/frame_writer.sv
src/frame_reader.sv
src/stats_regs.sv
src/nts_dispatcher.sv
bench/nts_dispatcher_sva.sv
bench/tb_nts_dispatcher.sv
